// File: verilog/cnn_pkg.sv
package cnn_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int I_F_BW    = 8;   // unsigned pixel channel
    localparam int W_BW      = 7;   // signed weight
    localparam int KX        = 3;
    localparam int KY        = 3;
    localparam int CI        = 2;   // input channels per pixel
    localparam int AK_BW     = 20;  // one channel's kernel sum
    localparam int ACI_BW    = 22;  // sum over all channels
    localparam int B_BW      = 16;
    localparam int O_BW      = 8;
    localparam int OUT_SHIFT = 4;
    localparam int IMG_W     = 8;
    localparam int IMG_H     = 8;

    // derived widths
    localparam int TAPS    = KX * KY;
    localparam int PROD_BW = I_F_BW + W_BW + 1;  // zero-extended pixel times weight
    localparam int PRE_BW  = ACI_BW + 1;         // channel sum plus bias
    localparam int COL_BW  = $clog2(IMG_W);
    localparam int ROW_BW  = $clog2(IMG_H);

    // output clamp limits
    localparam int O_UMAX = (1 << O_BW) - 1;
    localparam int O_SMAX = (1 << (O_BW - 1)) - 1;
    localparam int O_SMIN = -(1 << (O_BW - 1));

    // ========================================
    // latencies
    // ========================================
    localparam int KERNEL_LAT = 2;  // win_valid to kernel valid
    localparam int CORE_LAT   = 5;  // pixel strobe to o_out_valid

    // ========================================
    // types
    // ========================================
    // one pixel on the stream, channel c at index c
    typedef logic [CI-1:0][I_F_BW-1:0] pix_t;

    // tap index is r*KX + k
    // r = 0 is the oldest row, k = 0 the oldest column
    typedef logic [TAPS-1:0][I_F_BW-1:0] win_ch_t;
    typedef logic [TAPS-1:0][W_BW-1:0]   wgt_ch_t;  // two's complement per tap

    typedef struct packed {
        win_ch_t [CI-1:0] ch;
    } win_t;

    typedef struct packed {
        wgt_ch_t [CI-1:0] ch;
    } weight_t;

    typedef logic signed [ACI_BW-1:0] acc_t;

    typedef enum logic [1:0] {
        POST_RELU = 2'd0,
        POST_PASS = 2'd1,
        POST_ABS  = 2'd2
    } post_op_e;

    typedef enum logic {
        WG_FILL = 1'b0,  // rows 0 and 1 still loading
        WG_RUN  = 1'b1   // windows emitted
    } wg_state_e;

endpackage

// File: verilog/cnn_kernel.sv
`timescale 1ns/10ps
module cnn_kernel (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             i_in_valid,
    input  cnn_pkg::win_ch_t                 i_in_fmap,
    input  cnn_pkg::wgt_ch_t                 i_cnn_weight,
    output logic                             o_ot_valid,
    output logic signed [cnn_pkg::AK_BW-1:0] o_ot_kernel_acc
);
    import cnn_pkg::*;

    logic [KERNEL_LAT-1:0]      r_valid;  // one bit per stage
    logic signed [PROD_BW-1:0]  r_prod [TAPS];
    logic signed [AK_BW-1:0]    tree_sum;

    // ========================================
    // valid tracking
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[KERNEL_LAT-2:0], i_in_valid};
        end
    end

    assign o_ot_valid = r_valid[KERNEL_LAT-1];

    // ========================================
    // stage 1: products
    // ========================================
    // pixel gets a zero msb so the multiply stays signed
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int t = 0; t < TAPS; t++) begin
                r_prod[t] <= PROD_BW'($signed({1'b0, i_in_fmap[t]}))
                           * PROD_BW'($signed(i_cnn_weight[t]));
            end
        end
    end

    // ========================================
    // stage 2: adder tree
    // ========================================
    always_comb begin
        tree_sum = '0;
        for (int t = 0; t < TAPS; t++) begin
            tree_sum = tree_sum + AK_BW'(r_prod[t]);  // sign extended
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid[0]) begin
            o_ot_kernel_acc <= tree_sum;
        end
    end

    a_kernel_lat : assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid, KERNEL_LAT));

endmodule

// File: verilog/cnn_window_gen.sv
`timescale 1ns/10ps
module cnn_window_gen (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          i_pix_valid,
    input  cnn_pkg::pix_t i_pix,
    output logic          o_win_valid,
    output cnn_pkg::win_t o_win
);
    import cnn_pkg::*;

    logic [COL_BW-1:0] col;
    logic [ROW_BW-1:0] row;
    wg_state_e         state;

    pix_t lb_prev [IMG_W];  // row y-1
    pix_t lb_old  [IMG_W];  // row y-2
    pix_t rd_prev;
    pix_t rd_old;
    pix_t col_in  [KY];     // new column entering the window

    pix_t sh [KY][KX];      // window taps by row and column

    // ========================================
    // raster counters and state
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col   <= '0;
            row   <= '0;
            state <= WG_FILL;
        end else if (i_pix_valid) begin
            if (col == COL_BW'(IMG_W - 1)) begin
                col <= '0;
                if (row == ROW_BW'(IMG_H - 1)) begin
                    row   <= '0;
                    state <= WG_FILL;  // next frame starts fresh
                end else begin
                    row <= row + ROW_BW'(1);
                    if (row == ROW_BW'(KY - 2)) begin
                        state <= WG_RUN;
                    end
                end
            end else begin
                col <= col + COL_BW'(1);
            end
        end
    end

    // emit once three full columns of the current row are in
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_pix_valid && (state == WG_RUN) && (col >= COL_BW'(KX - 1));
        end
    end

    // ========================================
    // line buffers
    // ========================================
    assign rd_prev = lb_prev[col];
    assign rd_old  = lb_old[col];

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            lb_old[col]  <= rd_prev;  // y-1 ages to y-2
            lb_prev[col] <= i_pix;
        end
    end

    assign col_in[0] = rd_old;
    assign col_in[1] = rd_prev;
    assign col_in[2] = i_pix;

    // shift window reloads at column 0 so rows never mix
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            for (int r = 0; r < KY; r++) begin
                for (int k = 0; k < KX - 1; k++) begin
                    sh[r][k] <= (col == '0) ? '0 : sh[r][k+1];
                end
                sh[r][KX-1] <= col_in[r];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < CI; c++) begin
            for (int r = 0; r < KY; r++) begin
                for (int k = 0; k < KX; k++) begin
                    o_win.ch[c][r*KX + k] = sh[r][k][c];
                end
            end
        end
    end

    // run state only while the row counter is past the fill rows
    a_state_row : assert property (@(posedge clk) disable iff (!reset_n)
        (state == WG_RUN) == (int'(row) >= KY - 1));

endmodule

// File: verilog/cnn_acc_ci.sv
`timescale 1ns/10ps
module cnn_acc_ci (
    input  logic             clk,
    input  logic             reset_n,
    input  cnn_pkg::weight_t i_cnn_weight,
    input  logic             i_in_valid,
    input  cnn_pkg::win_t    i_window,
    output logic             o_ot_valid,
    output cnn_pkg::acc_t    o_ot_ci_acc
);
    import cnn_pkg::*;

    logic [CI-1:0]           k_valid;
    logic signed [AK_BW-1:0] k_sum [CI];
    acc_t                    ci_sum;
    logic                    all_valid;

    // ========================================
    // one kernel per input channel
    // ========================================
    for (genvar g = 0; g < CI; g++) begin : gen_kernel
        cnn_kernel u_cnn_kernel (
            .clk             (clk),
            .reset_n         (reset_n),
            .i_in_valid      (i_in_valid),
            .i_in_fmap       (i_window.ch[g]),
            .i_cnn_weight    (i_cnn_weight.ch[g]),
            .o_ot_valid      (k_valid[g]),
            .o_ot_kernel_acc (k_sum[g])
        );
    end

    assign all_valid = &k_valid;

    // ========================================
    // channel sum
    // ========================================
    always_comb begin
        ci_sum = '0;
        for (int c = 0; c < CI; c++) begin
            ci_sum = ci_sum + ACI_BW'(k_sum[c]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= all_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (all_valid) begin
            o_ot_ci_acc <= ci_sum;
        end
    end

    // kernels share one valid, a split means a broken pipeline
    a_valid_agree : assert property (@(posedge clk) disable iff (!reset_n)
        (k_valid == '0) || all_valid);

endmodule

// File: verilog/cnn_post.sv
`timescale 1ns/10ps
module cnn_post (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_in_valid,
    input  cnn_pkg::acc_t                   i_acc,
    input  logic signed [cnn_pkg::B_BW-1:0] i_bias,
    input  cnn_pkg::post_op_e               i_post_op,
    output logic                            o_out_valid,
    output logic [cnn_pkg::O_BW-1:0]        o_out
);
    import cnn_pkg::*;

    logic signed [PRE_BW-1:0] pre;      // sum plus bias
    logic signed [PRE_BW-1:0] act;
    logic signed [PRE_BW-1:0] shifted;
    logic [O_BW-1:0]          sat;

    always_comb begin
        pre = PRE_BW'(i_acc) + PRE_BW'(i_bias);

        case (i_post_op)
            POST_RELU : act = pre[PRE_BW-1] ? '0 : pre;
            POST_ABS  : act = pre[PRE_BW-1] ? -pre : pre;
            default   : act = pre;  // pass keeps the sign
        endcase

        shifted = act >>> OUT_SHIFT;

        // ========================================
        // saturation
        // ========================================
        if (i_post_op == POST_PASS) begin
            if (shifted > PRE_BW'(O_SMAX)) begin
                sat = O_BW'(O_SMAX);
            end else if (shifted < PRE_BW'(O_SMIN)) begin
                sat = O_BW'(O_SMIN);
            end else begin
                sat = shifted[O_BW-1:0];
            end
        end else begin
            // relu and abs leave nothing negative
            sat = (shifted > PRE_BW'(O_UMAX)) ? O_BW'(O_UMAX) : shifted[O_BW-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= i_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            o_out <= sat;
        end
    end

    a_relu_zero : assert property (@(posedge clk) disable iff (!reset_n)
        (i_in_valid && (i_post_op == POST_RELU) && pre[PRE_BW-1]) |=> (o_out == '0));

endmodule

// File: verilog/cnn_core.sv
`timescale 1ns/10ps
module cnn_core (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_pix_valid,
    input  cnn_pkg::pix_t                   i_pix,
    input  cnn_pkg::weight_t                i_weight,
    input  logic signed [cnn_pkg::B_BW-1:0] i_bias,
    input  cnn_pkg::post_op_e               i_post_op,
    output logic                            o_out_valid,
    output logic [cnn_pkg::O_BW-1:0]        o_out
);
    import cnn_pkg::*;

    logic win_valid;
    win_t win;
    logic acc_valid;
    acc_t acc;

    // ========================================
    // decode
    // ========================================
    cnn_window_gen u_cnn_window_gen (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (win_valid),
        .o_win       (win)
    );

    // ========================================
    // execute
    // ========================================
    cnn_acc_ci u_cnn_acc_ci (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_cnn_weight (i_weight),
        .i_in_valid   (win_valid),
        .i_window     (win),
        .o_ot_valid   (acc_valid),
        .o_ot_ci_acc  (acc)
    );

    // ========================================
    // result
    // ========================================
    cnn_post u_cnn_post (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (acc_valid),
        .i_acc       (acc),
        .i_bias      (i_bias),
        .i_post_op   (i_post_op),
        .o_out_valid (o_out_valid),
        .o_out       (o_out)
    );

endmodule

// File: sim/tb_cnn_core.sv
`timescale 1ns/10ps
module tb_cnn_core;
    import cnn_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 5;
    localparam int FRAMES          = 6;
    localparam int OUTS_PER_FRAME  = (IMG_W - KX + 1) * (IMG_H - KY + 1);
    localparam int WATCHDOG_CYCLES = FRAMES * IMG_W * IMG_H * 4 + 100;
    localparam int SEED            = 32'h52b;

    // output ranges of the post stage
    localparam int UNS_MAX = 255;
    localparam int SGN_MAX = 127;
    localparam int SGN_MIN = -128;

    typedef struct packed {
        int              due;    // cycle the strobe is expected
        int              frame;
        int              row;
        int              col;
        post_op_e        op;
        logic [O_BW-1:0] value;
    } expect_t;

    logic                   clk;
    logic                   reset_n;
    logic                   i_pix_valid;
    pix_t                   i_pix;
    weight_t                i_weight;
    logic signed [B_BW-1:0] i_bias;
    post_op_e               i_post_op;
    logic                   o_out_valid;
    logic [O_BW-1:0]        o_out;

    int       frame_pix [CI][IMG_H][IMG_W];
    int       wgt [CI][TAPS];
    int       bias;
    post_op_e cur_op;
    int       cur_frame;
    int       cycle_count;
    int       out_count;
    expect_t  exp_q [$];

    cnn_core u_cnn_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .i_weight    (i_weight),
        .i_bias      (i_bias),
        .i_post_op   (i_post_op),
        .o_out_valid (o_out_valid),
        .o_out       (o_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic string op_label(input post_op_e op);
        case (op)
            POST_RELU : return "relu";
            POST_PASS : return "pass";
            default   : return "abs";
        endcase
    endfunction

    function automatic string test_name(input expect_t e);
        return $sformatf("frame%0d_%s_y%0d_x%0d", e.frame, op_label(e.op), e.row, e.col);
    endfunction

    // ========================================
    // reference model
    // ========================================
    // window ends at (y, x), taps in raster order
    function automatic logic [O_BW-1:0] model_output(input int y, input int x);
        int sum;
        int act;
        int shifted;
        sum = bias;
        for (int c = 0; c < CI; c++) begin
            for (int r = 0; r < KY; r++) begin
                for (int k = 0; k < KX; k++) begin
                    sum += frame_pix[c][y - (KY - 1) + r][x - (KX - 1) + k] * wgt[c][r*KX + k];
                end
            end
        end
        case (cur_op)
            POST_RELU : act = (sum < 0) ? 0 : sum;
            POST_ABS  : act = (sum < 0) ? -sum : sum;
            default   : act = sum;
        endcase
        shifted = act >>> OUT_SHIFT;
        if (cur_op == POST_PASS) begin
            if (shifted > SGN_MAX) shifted = SGN_MAX;
            if (shifted < SGN_MIN) shifted = SGN_MIN;
        end else begin
            if (shifted > UNS_MAX) shifted = UNS_MAX;
        end
        return O_BW'(shifted);
    endfunction

    // draws a frame and sets the static config inputs
    task automatic load_frame(input int f);
        bit extreme;
        int ext_w;
        extreme = (f % 3) == 2;  // forces saturation
        ext_w   = ($urandom_range(0, 1) != 0) ? 63 : -64;
        cur_frame = f;
        cur_op = (f < 2) ? POST_RELU : ((f < 4) ? POST_PASS : POST_ABS);
        bias = int'($urandom_range(0, 65535)) - 32768;
        for (int c = 0; c < CI; c++) begin
            for (int t = 0; t < TAPS; t++) begin
                wgt[c][t] = extreme ? ext_w : int'($urandom_range(0, 127)) - 64;
                i_weight.ch[c][t] = W_BW'(wgt[c][t]);
            end
            for (int y = 0; y < IMG_H; y++) begin
                for (int x = 0; x < IMG_W; x++) begin
                    frame_pix[c][y][x] = extreme ? 255 : int'($urandom_range(0, 255));
                end
            end
        end
        i_bias    = B_BW'(bias);
        i_post_op = cur_op;
    endtask

    // one strobe, then a random idle gap
    task automatic send_pixel(input int y, input int x);
        expect_t e;
        int      gap;
        i_pix_valid = 1'b1;
        for (int c = 0; c < CI; c++) begin
            i_pix[c] = I_F_BW'(frame_pix[c][y][x]);
        end
        if (y >= KY - 1 && x >= KX - 1) begin
            e.due   = cycle_count + CORE_LAT;
            e.frame = cur_frame;
            e.row   = y;
            e.col   = x;
            e.op    = cur_op;
            e.value = model_output(y, x);
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
        gap = $urandom_range(0, 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ========================================
    // checker, sampled mid-cycle
    // ========================================
    always @(negedge clk) begin
        expect_t e;
        if (!reset_n) begin
            assert (!o_out_valid) else abort_run("o_out_valid went high during reset");
        end else if (o_out_valid) begin
            assert (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (e.due == cycle_count) else abort_run($sformatf(
                    "FAILED %s timing: expected cycle %0d, actual cycle %0d",
                    test_name(e), e.due, cycle_count));
                assert (o_out == e.value) else abort_run($sformatf(
                    "FAILED %s: expected %0d, actual %0d", test_name(e), e.value, o_out));
                out_count++;
            end else begin
                abort_run("an output strobe came with no complete window behind it");
            end
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle_count) else abort_run($sformatf(
                "an expected output for %s never arrived", test_name(exp_q[0])));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog timeout, the run took longer than the frames allow");
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin
        void'($urandom(SEED));
        reset_n     = 1'b0;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        i_weight    = '0;
        i_bias      = '0;
        i_post_op   = POST_RELU;
        cycle_count = 0;
        out_count   = 0;
        cur_frame   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int f = 0; f < FRAMES; f++) begin
            load_frame(f);
            for (int y = 0; y < IMG_H; y++) begin
                for (int x = 0; x < IMG_W; x++) begin
                    send_pixel(y, x);
                end
            end
            while (exp_q.size() != 0) begin  // drain before config changes
                @(posedge clk);
                #1;
            end
            assert (out_count == (f + 1) * OUTS_PER_FRAME) else abort_run($sformatf(
                "FAILED frame%0d output count: expected %0d, actual %0d",
                f, (f + 1) * OUTS_PER_FRAME, out_count));
            repeat (2) begin
                @(posedge clk);
                #1;
            end
        end

        if (out_count == FRAMES * OUTS_PER_FRAME && exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("the total number of outputs is wrong at the end of the run");
        end
    end

endmodule

// File: list.f
verilog/cnn_pkg.sv
verilog/cnn_kernel.sv
verilog/cnn_window_gen.sv
verilog/cnn_acc_ci.sv
verilog/cnn_post.sv
verilog/cnn_core.sv
sim/tb_cnn_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cnn_core \
    --Mdir obj_dir \
    -o tb_cnn_core \
    -f list.f

# a $fatal in the testbench gives a failing exit status
./obj_dir/tb_cnn_core
